// ==== design/supervisor_cfg.svh ====
`ifndef SUPERVISOR_CFG_SVH
`define SUPERVISOR_CFG_SVH

// width of the target code address.
// the program counter, the breakpoint registers and the host RAM
// pointer all share it.
`define CODE_AW 10

// number of address breakpoints.
// the register map reserves four slots.
`define NUM_BP 4

// program RAM depth in 16-bit words.
// this must not exceed the reach of CODE_AW.
`define PM_DEPTH 1024

// opcode that halts the target after it retires.
`define BREAK_OPCODE 16'hffff

`endif

// ==== design/dbg_reg_pkg.sv ====
package dbg_reg_pkg;

    // host register map.
    // the first four slots are the breakpoints.
    // the low address bits select among them.
    typedef enum logic [3:0] {
        dbg_bp0          = 4'h0,
        dbg_bp1          = 4'h1,
        dbg_bp2          = 4'h2,
        dbg_bp3          = 4'h3,
        dbg_bus_ctrl     = 4'h4,
        dbg_force_opcode = 4'h5,
        dbg_pm_addr      = 4'h6,
        dbg_pm_data      = 4'h7,
        // read-only status from here on.
        dbg_bp_status    = 4'h8,
        dbg_exr_shadow   = 4'h9,
        dbg_tg_code_addr = 4'ha
    } dbg_addr_e;

    // data word on the host register port.
    typedef logic [15:0] host_word_t;

    // code bus control, written through bus_ctrl.
    // step is bit 3 and forced_ready is bit 0.
    typedef struct packed {
        logic step;
        logic divert;
        logic hold_reset;
        logic forced_ready;
    } bus_ctrl_t;

endpackage

// ==== design/fetch_pkg.sv ====
`include "supervisor_cfg.svh"

package fetch_pkg;
    import dbg_reg_pkg::*;

    // opcode on the target code bus.
    typedef logic [15:0] code_word_t;

    // target code address.
    typedef logic [`CODE_AW-1:0] code_addr_t;

    // one retired instruction, reported in the cycle it is accepted.
    typedef struct packed {
        logic       valid;
        code_addr_t addr;
        code_word_t opcode;
    } retire_t;

    // supervisor settings for the breakpoint unit and the code bus gate.
    // bp_written pulses for one cycle after any breakpoint write.
    typedef struct packed {
        code_addr_t [`NUM_BP-1:0] bp_addr;
        bus_ctrl_t                bus_ctrl;
        code_word_t               force_opcode;
        logic                     bp_written;
    } bp_ctrl_t;

endpackage

// ==== design/debug_reg_block.sv ====
`timescale 1ns/100ps
`include "supervisor_cfg.svh"

module debug_reg_block
    import dbg_reg_pkg::*;
    import fetch_pkg::*;
(
    input  logic       sysreset,
    input  logic       sysclk,
    input  logic       reg_wr,
    input  dbg_addr_e  reg_addr,
    input  host_word_t reg_wdata,
    output host_word_t reg_rdata,
    output bp_ctrl_t   bp_ctrl,
    output code_addr_t pm_addr,
    output code_word_t pm_wdata,
    output logic       pm_wren,
    input  code_word_t pm_rdata,
    input  logic       bp_hit,
    input  code_word_t exr_shadow,
    input  code_addr_t tg_code_addr
);

    localparam int BP_IW = $clog2(`NUM_BP);

    code_addr_t [`NUM_BP-1:0] bp_addr_q;
    bus_ctrl_t                bus_ctrl_q;
    code_word_t               force_opcode_q;
    code_addr_t               pm_addr_q;
    code_word_t               pm_data_q;
    logic                     pm_wren_q;
    logic                     bp_written_q;
    logic                     bp_wr;
    logic [3:0]               addr_bits;
    logic [BP_IW-1:0]         bp_idx;

    assign addr_bits = reg_addr;
    assign bp_idx    = addr_bits[BP_IW-1:0];
    assign bp_wr     = reg_wr && (reg_addr inside {dbg_bp0, dbg_bp1, dbg_bp2, dbg_bp3});

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            bp_addr_q      <= '0;
            bus_ctrl_q     <= '0;
            force_opcode_q <= '0;
            pm_addr_q      <= '0;
            pm_data_q      <= '0;
            pm_wren_q      <= 1'b0;
            bp_written_q   <= 1'b0;
        end else begin
            // resume pulse travels with the new breakpoint value.
            bp_written_q <= bp_wr;
            // the RAM write lands one cycle after the data register loads.
            pm_wren_q    <= reg_wr && (reg_addr == dbg_pm_data);
            if (reg_wr) begin
                case (reg_addr)
                    dbg_bp0, dbg_bp1, dbg_bp2, dbg_bp3: begin
                        bp_addr_q[bp_idx] <= reg_wdata[`CODE_AW-1:0];
                    end
                    dbg_bus_ctrl: begin
                        bus_ctrl_q <= bus_ctrl_t'(reg_wdata[$bits(bus_ctrl_t)-1:0]);
                    end
                    dbg_force_opcode: begin
                        force_opcode_q <= reg_wdata;
                    end
                    dbg_pm_addr: begin
                        pm_addr_q <= reg_wdata[`CODE_AW-1:0];
                    end
                    dbg_pm_data: begin
                        pm_data_q <= reg_wdata;
                    end
                    // status addresses ignore writes.
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (reg_addr)
            dbg_bp0, dbg_bp1, dbg_bp2, dbg_bp3: reg_rdata = host_word_t'(bp_addr_q[bp_idx]);
            dbg_bus_ctrl:     reg_rdata = host_word_t'(bus_ctrl_q);
            dbg_force_opcode: reg_rdata = force_opcode_q;
            dbg_pm_addr:      reg_rdata = host_word_t'(pm_addr_q);
            dbg_pm_data:      reg_rdata = pm_rdata;
            dbg_bp_status:    reg_rdata = host_word_t'(bp_hit);
            dbg_exr_shadow:   reg_rdata = exr_shadow;
            dbg_tg_code_addr: reg_rdata = host_word_t'(tg_code_addr);
            default:          reg_rdata = '0;
        endcase
    end

    assign bp_ctrl = '{
        bp_addr:      bp_addr_q,
        bus_ctrl:     bus_ctrl_q,
        force_opcode: force_opcode_q,
        bp_written:   bp_written_q
    };

    assign pm_addr  = pm_addr_q;
    assign pm_wdata = pm_data_q;
    assign pm_wren  = pm_wren_q;

    // each RAM store is a single-cycle strobe.
    // back-to-back pm_data writes from the host would break this.
    a_pm_wren_single: assert property (
        @(posedge sysreset) disable iff (sysclk) pm_wren |=> !pm_wren
    );

endmodule

// ==== design/breakpoint_unit.sv ====
`timescale 1ns/100ps
`include "supervisor_cfg.svh"

module breakpoint_unit
    import fetch_pkg::*;
(
    input  logic       sysreset,
    input  logic       sysclk,
    input  bp_ctrl_t   bp_ctrl,
    input  code_addr_t code_addr,
    input  code_word_t ram_word,
    input  retire_t    retire,
    input  logic       program_break,
    output code_word_t code_in,
    output logic       code_ready,
    output logic       bp_hit,
    output code_word_t exr_shadow,
    output logic       tg_reset
);

    logic [`NUM_BP-1:0] addr_eq;
    logic               addr_match;
    logic               bp_matched;
    logic               divert;
    logic               live_retire;
    logic               halt_now;

    assign divert = bp_ctrl.bus_ctrl.divert;

    always_comb begin
        for (int i = 0; i < `NUM_BP; i++) begin
            addr_eq[i] = (code_addr == bp_ctrl.bp_addr[i]);
        end
    end

    assign addr_match = |addr_eq;

    // only retires from program RAM count toward a halt.
    assign live_retire = retire.valid && !divert;
    assign halt_now    = live_retire
                       && (addr_match || bp_matched || bp_ctrl.bus_ctrl.step || program_break);

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            bp_matched <= 1'b0;
            bp_hit     <= 1'b0;
            exr_shadow <= '0;
        end else begin
            if (live_retire) begin
                exr_shadow <= retire.opcode;
            end
            // a breakpoint write releases the target.
            if (bp_ctrl.bp_written) begin
                bp_matched <= 1'b0;
                bp_hit     <= 1'b0;
            end else begin
                if (addr_match && !divert) begin
                    bp_matched <= 1'b1;
                end
                // the matching word retires first, then the bus stalls.
                if (halt_now) begin
                    bp_hit <= 1'b1;
                end
            end
        end
    end

    // code bus gate.
    assign code_in    = divert ? bp_ctrl.force_opcode : ram_word;
    assign code_ready = divert ? bp_ctrl.bus_ctrl.forced_ready : !bp_hit;
    assign tg_reset   = bp_ctrl.bus_ctrl.hold_reset;

    // a halted target retires nothing from RAM.
    a_hit_stalls_fetch: assert property (
        @(posedge sysreset) disable iff (sysclk) bp_hit && !divert |-> !retire.valid
    );

    // the fetch unit stays quiet while held in reset.
    a_hold_no_retire: assert property (
        @(posedge sysreset) disable iff (sysclk) bp_ctrl.bus_ctrl.hold_reset |-> !retire.valid
    );

endmodule

// ==== design/program_ram.sv ====
`timescale 1ns/100ps
`include "supervisor_cfg.svh"

module program_ram
    import fetch_pkg::*;
(
    input  logic       sysreset,
    input  code_addr_t a_addr,
    input  code_word_t a_wdata,
    input  logic       a_wren,
    output code_word_t a_rdata,
    input  code_addr_t b_addr,
    output code_word_t b_rdata
);

    code_word_t mem [`PM_DEPTH];

    // the depth has to fit the code address range.
    if (`PM_DEPTH > (1 << `CODE_AW)) begin : g_depth_check
        $error("program RAM deeper than the code address range");
    end

    // port A is the host side and the only writer.
    always_ff @(posedge sysreset) begin
        if (a_wren) begin
            mem[a_addr] <= a_wdata;
        end
    end

    // both reads are combinational.
    // a fetch sees its word in the same cycle the address is driven.
    assign a_rdata = mem[a_addr];
    assign b_rdata = mem[b_addr];

endmodule

// ==== design/target_fetch_unit.sv ====
`timescale 1ns/100ps
`include "supervisor_cfg.svh"

module target_fetch_unit
    import fetch_pkg::*;
(
    input  logic       sysreset,
    input  logic       sysclk,
    input  logic       tg_reset,
    input  logic       code_ready,
    input  code_word_t code_in,
    output code_addr_t code_addr,
    output retire_t    retire,
    output logic       program_break
);

    code_addr_t pc_q;
    logic       accept;

    // a word is taken whenever the bus is ready and the target runs.
    assign accept = code_ready && !tg_reset;

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            pc_q <= '0;
        end else if (tg_reset) begin
            // held at the reset vector.
            pc_q <= '0;
        end else if (accept) begin
            pc_q <= pc_q + code_addr_t'(1);
        end
    end

    assign code_addr = pc_q;

    // the retire report is the accepted word and where it came from.
    assign retire = '{
        valid:  accept,
        addr:   pc_q,
        opcode: code_in
    };

    // the break opcode still retires; the halt follows on the same edge.
    assign program_break = accept && (code_in == `BREAK_OPCODE);

endmodule

// ==== design/supervised_core.sv ====
`timescale 1ns/100ps

module supervised_core
    import dbg_reg_pkg::*;
    import fetch_pkg::*;
(
    input  logic       sysreset,
    input  logic       sysclk,
    input  logic       reg_wr,
    input  dbg_addr_e  reg_addr,
    input  host_word_t reg_wdata,
    output host_word_t reg_rdata,
    output retire_t    retire,
    output logic       break_mode
);

    bp_ctrl_t   bp_ctrl;
    code_addr_t pm_addr;
    code_word_t pm_wdata;
    logic       pm_wren;
    code_word_t pm_rdata;
    logic       bp_hit;
    code_word_t exr_shadow;
    code_addr_t code_addr;
    code_word_t ram_word;
    code_word_t code_in;
    logic       code_ready;
    logic       tg_reset;
    logic       program_break;

    debug_reg_block u_regs (
        .sysreset     (sysreset),
        .sysclk       (sysclk),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .bp_ctrl      (bp_ctrl),
        .pm_addr      (pm_addr),
        .pm_wdata     (pm_wdata),
        .pm_wren      (pm_wren),
        .pm_rdata     (pm_rdata),
        .bp_hit       (bp_hit),
        .exr_shadow   (exr_shadow),
        .tg_code_addr (code_addr)
    );

    breakpoint_unit u_bp (
        .sysreset      (sysreset),
        .sysclk        (sysclk),
        .bp_ctrl       (bp_ctrl),
        .code_addr     (code_addr),
        .ram_word      (ram_word),
        .retire        (retire),
        .program_break (program_break),
        .code_in       (code_in),
        .code_ready    (code_ready),
        .bp_hit        (bp_hit),
        .exr_shadow    (exr_shadow),
        .tg_reset      (tg_reset)
    );

    // port A for the host, port B for target fetch.
    program_ram u_ram (
        .sysreset (sysreset),
        .a_addr   (pm_addr),
        .a_wdata  (pm_wdata),
        .a_wren   (pm_wren),
        .a_rdata  (pm_rdata),
        .b_addr   (code_addr),
        .b_rdata  (ram_word)
    );

    target_fetch_unit u_target (
        .sysreset      (sysreset),
        .sysclk        (sysclk),
        .tg_reset      (tg_reset),
        .code_ready    (code_ready),
        .code_in       (code_in),
        .code_addr     (code_addr),
        .retire        (retire),
        .program_break (program_break)
    );

    assign break_mode = !code_ready;

endmodule

// ==== bench/tb_supervised_core.sv ====
`timescale 1ns/100ps
`include "supervisor_cfg.svh"

module tb_supervised_core
    import dbg_reg_pkg::*;
    import fetch_pkg::*;
();

    localparam host_word_t FAR_ADDR    = 16'd1023;
    localparam host_word_t FREE_STOP   = 16'd40;
    localparam host_word_t BP_ADDR     = 16'd50;
    localparam host_word_t BREAK_ADDR  = 16'd60;
    localparam host_word_t RESTART_BP  = 16'd8;
    localparam int         PROG_LEN    = 64;
    localparam int         STEPS       = 4;
    localparam int         HALT_LIMIT  = 200;
    // setup, load and readback, four runs to a halt, then the steps.
    localparam int TEST_CYCLES = 40 + 7 * PROG_LEN + 4 * (PROG_LEN + 20) + 10 * STEPS;
    localparam int WATCHDOG_NS = 2 * 20 * TEST_CYCLES;

    logic       sysreset;
    logic       sysclk;
    logic       reg_wr;
    dbg_addr_e  reg_addr;
    host_word_t reg_wdata;
    host_word_t reg_rdata;
    retire_t    retire;
    logic       break_mode;

    // model of what the host has programmed.
    code_word_t prog [`PM_DEPTH];
    code_addr_t model_bp [`NUM_BP];
    bus_ctrl_t  model_bus;
    code_word_t model_force;
    code_addr_t model_pm_addr;
    code_addr_t model_pc;
    int         retire_count;
    int         open_cycles;
    int         error_count;
    logic       checking;
    string      test_name;

    supervised_core DUT (
        .sysreset   (sysreset),
        .sysclk     (sysclk),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .retire     (retire),
        .break_mode (break_mode)
    );

    always #10 sysreset = ~sysreset;

    task end_with_failure();
        error_count++;
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            end_with_failure();
        end
    endtask

    // word the target should retire from address pc.
    function automatic retire_t predict_retire(input code_addr_t pc);
        retire_t r;
        r.valid  = 1'b1;
        r.addr   = pc;
        r.opcode = model_bus.divert ? model_force : prog[pc];
        return r;
    endfunction

    function automatic logic is_breakpoint(input code_addr_t a);
        logic found;
        found = 1'b0;
        for (int i = 0; i < `NUM_BP; i++) begin
            if (model_bp[i] == a) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // code address after the target halts when it runs from start.
    // the halting word retires first.
    function automatic code_addr_t halt_address_after(input code_addr_t start);
        code_addr_t a;
        a = start;
        for (int n = 0; n < HALT_LIMIT; n++) begin
            if (model_bus.step || is_breakpoint(a) || prog[a] == `BREAK_OPCODE) begin
                return a + code_addr_t'(1);
            end
            a = a + code_addr_t'(1);
        end
        return a;
    endfunction

    task automatic write_register(input dbg_addr_e a, input host_word_t d);
        @(posedge sysreset);
        reg_wr    <= 1'b1;
        reg_addr  <= a;
        reg_wdata <= d;
        @(posedge sysreset);
        reg_wr <= 1'b0;
        // the register loads on this edge.
        case (a)
            dbg_bp0, dbg_bp1, dbg_bp2, dbg_bp3: model_bp[int'(a)] = d[`CODE_AW-1:0];
            dbg_bus_ctrl:     model_bus = bus_ctrl_t'(d[3:0]);
            dbg_force_opcode: model_force = d;
            dbg_pm_addr:      model_pm_addr = d[`CODE_AW-1:0];
            dbg_pm_data:      prog[model_pm_addr] = d;
            default: begin
            end
        endcase
    endtask

    task automatic expect_register(input string what, input dbg_addr_e a,
                                   input host_word_t expected);
        @(posedge sysreset);
        reg_addr <= a;
        @(negedge sysreset);
        compare_value(what, expected, reg_rdata);
    endtask

    // break_mode has to drop (or already be low) and then rise again.
    task automatic wait_for_halt();
        int n;
        n = 0;
        @(negedge sysreset);
        while (break_mode !== 1'b0 && n < HALT_LIMIT) begin
            @(negedge sysreset);
            n++;
        end
        while (break_mode !== 1'b1 && n < HALT_LIMIT) begin
            @(negedge sysreset);
            n++;
        end
        assert (n < HALT_LIMIT) else begin
            $display("%s: target did not halt within %0d cycles", test_name, HALT_LIMIT);
            end_with_failure();
        end
    endtask

    // retire stream compare at mid-cycle.
    always @(negedge sysreset) begin
        retire_t expected;
        if (checking) begin
            if (model_bus.hold_reset) begin
                model_pc = '0;
            end
            if (model_bus.divert && model_bus.forced_ready) begin
                open_cycles++;
            end
            if (retire.valid === 1'b1) begin
                expected = predict_retire(model_pc);
                compare_value("retire address", expected.addr, retire.addr);
                compare_value("retire opcode", expected.opcode, retire.opcode);
                model_pc = model_pc + code_addr_t'(1);
                retire_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        end_with_failure();
    end

    initial begin
        code_addr_t start;
        code_addr_t halt_pc;
        code_word_t word;
        int         count_before;
        void'($urandom(70016));
        sysreset      = 1'b0;
        sysclk        = 1'b1;
        reg_wr        = 1'b0;
        reg_addr      = dbg_bp0;
        reg_wdata     = '0;
        model_bus     = '0;
        model_force   = '0;
        model_pm_addr = '0;
        model_pc      = '0;
        retire_count  = 0;
        open_cycles   = 0;
        error_count   = 0;
        checking      = 1'b0;
        for (int i = 0; i < `NUM_BP; i++) begin
            model_bp[i] = '0;
        end
        repeat (4) @(posedge sysreset);
        sysclk <= 1'b0;

        // hold the target and park every breakpoint out of reach.
        test_name = "setup";
        write_register(dbg_bus_ctrl, 16'h0002);
        for (int i = 0; i < `NUM_BP; i++) begin
            write_register(dbg_addr_e'(i), FAR_ADDR);
        end

        test_name = "pm_load";
        for (int i = 0; i < PROG_LEN; i++) begin
            do begin
                word = 16'($urandom);
            end while (word == `BREAK_OPCODE);
            write_register(dbg_pm_addr, 16'(i));
            write_register(dbg_pm_data, word);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            write_register(dbg_pm_addr, 16'(i));
            expect_register("pm_data readback", dbg_pm_data, prog[i]);
        end

        test_name = "free_run";
        write_register(dbg_bp0, FREE_STOP);
        write_register(dbg_bp1, BP_ADDR);
        checking = 1'b1;
        write_register(dbg_bus_ctrl, 16'h0000);
        halt_pc = halt_address_after('0);
        wait_for_halt();
        compare_value("retire count", halt_pc, retire_count);
        expect_register("tg_code_addr", dbg_tg_code_addr, halt_pc);

        test_name = "breakpoint";
        start = halt_pc;
        count_before = retire_count;
        write_register(dbg_bp0, FAR_ADDR);
        halt_pc = halt_address_after(start);
        wait_for_halt();
        compare_value("retire count", halt_pc - start, retire_count - count_before);
        expect_register("tg_code_addr", dbg_tg_code_addr, halt_pc);
        expect_register("bp_status", dbg_bp_status, 16'h0001);
        expect_register("exr_shadow", dbg_exr_shadow, prog[halt_pc - code_addr_t'(1)]);

        test_name = "single_step";
        write_register(dbg_bus_ctrl, 16'h0008);
        for (int i = 0; i < STEPS; i++) begin
            start = halt_pc;
            count_before = retire_count;
            write_register(dbg_bp1, FAR_ADDR);
            halt_pc = halt_address_after(start);
            wait_for_halt();
            compare_value("step retires", halt_pc - start, retire_count - count_before);
            expect_register("tg_code_addr", dbg_tg_code_addr, halt_pc);
        end
        write_register(dbg_bus_ctrl, 16'h0000);

        test_name = "diversion";
        start = halt_pc;
        count_before = retire_count;
        write_register(dbg_force_opcode, 16'($urandom));
        open_cycles = 0;
        write_register(dbg_bus_ctrl, 16'h0005);
        write_register(dbg_bus_ctrl, 16'h0004);
        compare_value("diverted retires", open_cycles, retire_count - count_before);
        expect_register("exr_shadow", dbg_exr_shadow, prog[start - code_addr_t'(1)]);
        halt_pc = start + code_addr_t'(open_cycles);
        expect_register("tg_code_addr", dbg_tg_code_addr, halt_pc);
        write_register(dbg_bus_ctrl, 16'h0000);
        @(negedge sysreset);
        compare_value("break_mode", 1'b1, break_mode);

        test_name = "program_break";
        write_register(dbg_pm_addr, BREAK_ADDR);
        write_register(dbg_pm_data, `BREAK_OPCODE);
        start = halt_pc;
        count_before = retire_count;
        write_register(dbg_bp0, FAR_ADDR);
        halt_pc = halt_address_after(start);
        wait_for_halt();
        compare_value("retire count", halt_pc - start, retire_count - count_before);
        expect_register("tg_code_addr", dbg_tg_code_addr, halt_pc);
        expect_register("exr_shadow", dbg_exr_shadow, `BREAK_OPCODE);

        // pulse the target reset.
        // the breakpoint write also clears the halt.
        test_name = "target_reset";
        write_register(dbg_bus_ctrl, 16'h0002);
        write_register(dbg_bp2, RESTART_BP);
        count_before = retire_count;
        write_register(dbg_bus_ctrl, 16'h0000);
        halt_pc = halt_address_after('0);
        wait_for_halt();
        compare_value("retire count", halt_pc, retire_count - count_before);
        expect_register("tg_code_addr", dbg_tg_code_addr, halt_pc);

        if (error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

// ==== tb.f ====
+incdir+design
design/dbg_reg_pkg.sv
design/fetch_pkg.sv
design/debug_reg_block.sv
design/breakpoint_unit.sv
design/program_ram.sv
design/target_fetch_unit.sv
design/supervised_core.sv
bench/tb_supervised_core.sv

// ==== Bender.yml ====
package:
  name: supervised_core

sources:
  - include_dirs:
      - design
    files:
      - design/dbg_reg_pkg.sv
      - design/fetch_pkg.sv
      - design/debug_reg_block.sv
      - design/breakpoint_unit.sv
      - design/program_ram.sv
      - design/target_fetch_unit.sv
      - design/supervised_core.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/tb_supervised_core.sv
